/* src/pkt_link_cfg.svh */
`ifndef PKT_LINK_CFG_SVH
`define PKT_LINK_CFG_SVH

// Data bits carried by one beat of the link
`define PKT_WIDTH 8

// Packet FIFO entries, power of two
`define PKT_DEPTH 16

// Read side of the FIFO
// 0 = async read, 1 = SRAM read register, 2 = read register plus skid
`define PKT_OUTREG 1

// Longest legal frame in kept beats, CRC bytes included
// Must stay below PKT_DEPTH so one frame always fits
`define PKT_MAX_FRAME 12

`endif

/* src/pkt_pkg.sv */
`include "pkt_link_cfg.svh"

package pkt_pkg;

  // One beat of payload
  typedef logic [`PKT_WIDTH-1:0] data_t;

  // Committed occupancy, never reaches PKT_DEPTH
  typedef logic [$clog2(`PKT_DEPTH)-1:0] level_t;

  // CRC-16 shift register, bit 0 is the next to leave
  typedef logic [15:0] crc_t;

  // USB CRC-16, x^16 + x^15 + x^2 + 1 in reflected form
  localparam crc_t CRC_POLY = 16'hA001;

  // Register start value for every frame
  localparam crc_t CRC_INIT = 16'hFFFF;

  // Left in the register after a frame with a correct appended CRC
  localparam crc_t CRC_RESIDUAL = 16'hB001;

endpackage

/* src/crc16_check.sv */
`timescale 1ns/100ps

module crc16_check (
  input  logic           clock,
  input  logic           reset,
  input  logic           beat_i,
  input  logic           keep_i,
  input  logic           last_i,
  input  pkt_pkg::data_t data_i,
  output logic           save_o,
  output logic           drop_o
);

  pkt_pkg::crc_t crc_q;
  pkt_pkg::crc_t crc_next;
  logic          seen_q;
  logic          good_w;

  // Shift one byte through the register, LSB first
  function automatic pkt_pkg::crc_t crc_byte(input pkt_pkg::crc_t crc_in,
                                             input pkt_pkg::data_t data);
    pkt_pkg::crc_t crc;
    crc = crc_in;
    for (int i = 0; i < $bits(data); i++) begin
      if (crc[0] ^ data[i]) begin
        crc = (crc >> 1) ^ pkt_pkg::CRC_POLY;
      end else begin
        crc = crc >> 1;
      end
    end
    return crc;
  endfunction

  // Register value including the current beat, if it carries a byte
  assign crc_next = keep_i ? crc_byte(crc_q, data_i) : crc_q;

  // A frame without any kept byte cannot hold a CRC
  assign good_w = (seen_q || keep_i) && (crc_next == pkt_pkg::CRC_RESIDUAL);

  assign save_o = beat_i && last_i && good_w;
  assign drop_o = beat_i && last_i && !good_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      crc_q  <= pkt_pkg::CRC_INIT;
      seen_q <= 1'b0;
    end else if (beat_i && last_i) begin
      // Frame decided, start over for the next one
      crc_q  <= pkt_pkg::CRC_INIT;
      seen_q <= 1'b0;
    end else if (beat_i && keep_i) begin
      crc_q  <= crc_next;
      seen_q <= 1'b1;
    end
  end

endmodule

/* src/axis_skid.sv */
`timescale 1ns/100ps

module axis_skid #(
  parameter bit BYPASS = 1'b0
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           s_tvalid_i,
  output logic           s_tready_o,
  input  logic           s_tlast_i,
  input  pkt_pkg::data_t s_tdata_i,
  output logic           m_tvalid_o,
  input  logic           m_tready_i,
  output logic           m_tlast_o,
  output pkt_pkg::data_t m_tdata_o
);

  if (BYPASS) begin : g_bypass

    assign s_tready_o = m_tready_i;
    assign m_tvalid_o = s_tvalid_i;
    assign m_tlast_o  = s_tlast_i;
    assign m_tdata_o  = s_tdata_i;

  end else begin : g_skid

    logic           out_valid_q, out_last_q;
    logic           skid_valid_q, skid_last_q;
    pkt_pkg::data_t out_data_q, skid_data_q;
    logic           out_free_w;

    // Output register can take a new beat this cycle
    assign out_free_w = !out_valid_q || m_tready_i;

    // Ready depends only on a flop, so the path from m_tready_i ends here
    assign s_tready_o = !skid_valid_q;

    always_ff @(posedge clock) begin
      if (reset) begin
        out_valid_q  <= 1'b0;
        skid_valid_q <= 1'b0;
      end else if (out_free_w) begin
        out_valid_q  <= skid_valid_q || s_tvalid_i;
        skid_valid_q <= 1'b0;
      end else if (s_tvalid_i && !skid_valid_q) begin
        // Output stalled, park the incoming beat
        skid_valid_q <= 1'b1;
      end
    end

    always_ff @(posedge clock) begin
      if (out_free_w) begin
        {out_last_q, out_data_q} <= skid_valid_q ? {skid_last_q, skid_data_q}
                                                 : {s_tlast_i, s_tdata_i};
      end else if (!skid_valid_q) begin
        {skid_last_q, skid_data_q} <= {s_tlast_i, s_tdata_i};
      end
    end

    assign m_tvalid_o = out_valid_q;
    assign m_tlast_o  = out_last_q;
    assign m_tdata_o  = out_data_q;

  end

endmodule

/* src/packet_fifo.sv */
`timescale 1ns/100ps

module packet_fifo #(
  parameter int WIDTH  = 8,
  parameter int DEPTH  = 16,
  parameter int OUTREG = 1
) (
  input  logic            clock,
  input  logic            reset,
  output pkt_pkg::level_t level_o,
  input  logic            drop_i,
  input  logic            save_i,
  input  logic            redo_i,
  input  logic            next_i,
  input  logic            s_tvalid_i,
  output logic            s_tready_o,
  input  logic            s_tkeep_i,
  input  logic            s_tlast_i,
  input  pkt_pkg::data_t  s_tdata_i,
  output logic            m_tvalid_o,
  input  logic            m_tready_i,
  output logic            m_tlast_o,
  output pkt_pkg::data_t  m_tdata_o
);

  localparam int ABITS = $clog2(DEPTH);
  localparam int PTR_W = ABITS + 1;
  // One slot stays free so the level fits in ABITS bits
  localparam logic [PTR_W-1:0] FULL_USED = PTR_W'(DEPTH - 1);

  // Each entry holds the last flag above the data byte
  logic [WIDTH:0] sram [DEPTH];

  // Pointers carry a wrap bit above the address
  logic [PTR_W-1:0] waddr_q, paddr_q, raddr_q, rplay_q, optr_q;
  logic [PTR_W-1:0] waddr_next, paddr_next, rplay_next;
  logic [PTR_W-1:0] used_next, commit_next;
  logic [ABITS-1:0] level_q;
  logic             wready_q, hold_q;
  logic             store_w, avail_w, fetch_w, deliver_w;

  // Read-side stream before the packet hold gate
  logic             out_valid_w, out_ready_w, out_last_w;
  pkt_pkg::data_t   out_data_w;

  // Write side

  assign store_w = s_tvalid_i && wready_q && s_tkeep_i;

  always_comb begin
    waddr_next = waddr_q;
    if (drop_i) begin
      waddr_next = paddr_q;
    end else if (store_w) begin
      waddr_next = waddr_q + 1'b1;
    end
    // Save includes a kept last beat written this cycle
    paddr_next  = save_i ? waddr_next : paddr_q;
    rplay_next  = next_i ? optr_q : rplay_q;
    used_next   = waddr_next - rplay_next;
    commit_next = paddr_next - rplay_next;
  end

  always_ff @(posedge clock) begin
    if (store_w) begin
      sram[waddr_q[ABITS-1:0]] <= {s_tlast_i, s_tdata_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      waddr_q  <= '0;
      paddr_q  <= '0;
      rplay_q  <= '0;
      wready_q <= 1'b0;
      level_q  <= '0;
    end else begin
      waddr_q  <= waddr_next;
      paddr_q  <= paddr_next;
      rplay_q  <= rplay_next;
      // Space is held until the consumer acknowledges
      wready_q <= used_next != FULL_USED;
      level_q  <= commit_next[ABITS-1:0];
    end
  end

  assign s_tready_o = wready_q;
  assign level_o    = level_q;

  // Read side

  // Only committed beats are visible to the reader
  assign avail_w = raddr_q != paddr_q;

  // After a last beat the output waits for ack or nak
  assign m_tvalid_o  = out_valid_w && !hold_q;
  assign out_ready_w = m_tready_i && !hold_q;
  assign m_tlast_o   = out_last_w;
  assign m_tdata_o   = out_data_w;
  assign deliver_w   = m_tvalid_o && m_tready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      raddr_q <= '0;
      optr_q  <= '0;
      hold_q  <= 1'b0;
    end else begin
      if (redo_i) begin
        raddr_q <= rplay_q;
      end else if (fetch_w) begin
        raddr_q <= raddr_q + 1'b1;
      end

      // Delivered position, becomes the replay point on ack
      if (redo_i) begin
        optr_q <= rplay_q;
      end else if (deliver_w) begin
        optr_q <= optr_q + 1'b1;
      end

      if (next_i || redo_i) begin
        hold_q <= 1'b0;
      end else if (deliver_w && m_tlast_o) begin
        hold_q <= 1'b1;
      end
    end
  end

  if (OUTREG == 0) begin : g_async

    // Distributed RAM with an asynchronous read
    assign fetch_w     = avail_w && out_ready_w && !redo_i;
    assign out_valid_w = avail_w;
    assign {out_last_w, out_data_w} = sram[raddr_q[ABITS-1:0]];

  end else begin : g_outreg

    logic           xvalid_q, xlast_q, xready_w;
    pkt_pkg::data_t xdata_q;

    assign fetch_w = avail_w && (!xvalid_q || xready_w) && !redo_i;

    // SRAM read register, emptied on a replay
    always_ff @(posedge clock) begin
      if (reset || redo_i) begin
        xvalid_q <= 1'b0;
      end else if (fetch_w) begin
        xvalid_q <= 1'b1;
      end else if (xready_w) begin
        xvalid_q <= 1'b0;
      end
    end

    always_ff @(posedge clock) begin
      if (fetch_w) begin
        {xlast_q, xdata_q} <= sram[raddr_q[ABITS-1:0]];
      end
    end

    axis_skid #(
      .BYPASS(OUTREG == 1)
    ) skid_inst (
      .clock     (clock),
      .reset     (reset || redo_i),
      .s_tvalid_i(xvalid_q),
      .s_tready_o(xready_w),
      .s_tlast_i (xlast_q),
      .s_tdata_i (xdata_q),
      .m_tvalid_o(out_valid_w),
      .m_tready_i(out_ready_w),
      .m_tlast_o (out_last_w),
      .m_tdata_o (out_data_w)
    );

  end

endmodule

/* src/pkt_link.sv */
`timescale 1ns/100ps
`include "pkt_link_cfg.svh"

module pkt_link (
  input  logic            clock,
  input  logic            reset,
  input  logic            s_tvalid_i,
  output logic            s_tready_o,
  input  logic            s_tkeep_i,
  input  logic            s_tlast_i,
  input  pkt_pkg::data_t  s_tdata_i,
  output logic            m_tvalid_o,
  input  logic            m_tready_i,
  output logic            m_tlast_o,
  output pkt_pkg::data_t  m_tdata_o,
  input  logic            ack_i,
  input  logic            nak_i,
  output pkt_pkg::level_t level_o
);

  logic beat_w, save_w, drop_w;

  // Input beat accepted this cycle
  assign beat_w = s_tvalid_i && s_tready_o;

  crc16_check crc_inst (
    .clock (clock),
    .reset (reset),
    .beat_i(beat_w),
    .keep_i(s_tkeep_i),
    .last_i(s_tlast_i),
    .data_i(s_tdata_i),
    .save_o(save_w),
    .drop_o(drop_w)
  );

  // Ack frees the delivered packet, nak replays it
  packet_fifo #(
    .WIDTH (`PKT_WIDTH),
    .DEPTH (`PKT_DEPTH),
    .OUTREG(`PKT_OUTREG)
  ) fifo_inst (
    .clock     (clock),
    .reset     (reset),
    .level_o   (level_o),
    .drop_i    (drop_w),
    .save_i    (save_w),
    .redo_i    (nak_i),
    .next_i    (ack_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tkeep_i (s_tkeep_i),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

endmodule

/* bench/pkt_link_tb.sv */
`timescale 1ns/100ps
`include "pkt_link_cfg.svh"

module pkt_link_tb;

  localparam logic [31:0] SEED       = 32'hfc0c53f2;
  localparam int          FRAMES     = 60;
  localparam int          WAIT_LIMIT = 1000;
  localparam logic [15:0] USB_POLY   = 16'hA001;

  logic                          clock;
  logic                          reset;
  logic                          s_tvalid_i, s_tready_o, s_tkeep_i, s_tlast_i;
  logic [`PKT_WIDTH-1:0]         s_tdata_i, m_tdata_o;
  logic                          m_tvalid_o, m_tready_i, m_tlast_o;
  logic                          ack_i, nak_i;
  logic [$clog2(`PKT_DEPTH)-1:0] level_o;

  // Separate generator states keep both streams independent of process order
  logic [31:0] prod_state, cons_state;
  // Expected packets, bytes back to back with one length per packet
  logic [7:0]  exp_bytes[$];
  int          exp_lens[$];
  bit          producer_done, saw_full;
  int          errors;

  pkt_link pkt_link_inst (
    .clock     (clock),
    .reset     (reset),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tkeep_i (s_tkeep_i),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o),
    .ack_i     (ack_i),
    .nak_i     (nak_i),
    .level_o   (level_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Linear congruential step, returns a value below range
  function automatic int unsigned draw(inout logic [31:0] state, input int unsigned range);
    state = state * 32'd1664525 + 32'd1013904223;
    return (state >> 8) % range;
  endfunction

  // USB CRC-16, byte folded into the low end then shifted out LSB first
  function automatic logic [15:0] crc16_add(input logic [15:0] crc_in, input logic [7:0] value);
    logic [15:0] crc;
    crc = crc_in ^ {8'h00, value};
    repeat (8) begin
      crc = crc[0] ? ((crc >> 1) ^ USB_POLY) : (crc >> 1);
    end
    return crc;
  endfunction

  task automatic stop_with_error(input string line);
    errors++;
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Present one input beat and hold it until the DUT takes it
  task automatic send_beat(input logic keep, input logic last, input logic [7:0] data);
    int waited;
    bit accepted;
    waited = 0;
    accepted = 1'b0;
    @(posedge clock);
    s_tvalid_i <= 1'b1;
    s_tkeep_i  <= keep;
    s_tlast_i  <= last;
    s_tdata_i  <= data;
    while (!accepted) begin
      @(negedge clock);
      accepted = s_tready_o;
      waited++;
      assert (waited < WAIT_LIMIT)
        else stop_with_error("Timeout: the DUT did not accept an input beat");
      if (!accepted) begin
        @(posedge clock);
      end
    end
  endtask

  task automatic idle_input();
    @(posedge clock);
    s_tvalid_i <= 1'b0;
  endtask

  task automatic send_frames();
    logic [7:0]  frame[$];
    logic [15:0] crc;
    int          payload;
    bit          bad;
    for (int f = 0; f < FRAMES; f++) begin
      frame.delete();
      payload = 1 + draw(prod_state, `PKT_MAX_FRAME - 2);
      crc = 16'hFFFF;
      for (int i = 0; i < payload; i++) begin
        frame.push_back(8'(draw(prod_state, 256)));
        crc = crc16_add(crc, frame[i]);
      end
      // Complement goes out low byte first
      crc = ~crc;
      frame.push_back(crc[7:0]);
      frame.push_back(crc[15:8]);
      bad = draw(prod_state, 4) == 0;
      if (bad) begin
        frame[payload + draw(prod_state, 2)] ^= 8'(1 + draw(prod_state, 255));
      end else begin
        foreach (frame[i]) exp_bytes.push_back(frame[i]);
        exp_lens.push_back(frame.size());
      end
      for (int i = 0; i < frame.size(); i++) begin
        if (draw(prod_state, 6) == 0) begin
          send_beat(1'b0, 1'b0, 8'(draw(prod_state, 256)));
        end
        if (draw(prod_state, 4) == 0) begin
          idle_input();
        end
        send_beat(1'b1, i == frame.size() - 1, frame[i]);
      end
    end
    idle_input();
    producer_done = 1'b1;
  endtask

  task automatic take_frames();
    int idx, idle, acked, stall;
    bit pulse_nak;
    idx = 0;
    idle = 0;
    acked = 0;
    stall = 0;
    while (!producer_done || exp_lens.size() > 0) begin
      @(posedge clock);
      m_tready_i <= (stall == 0) && (draw(cons_state, 4) != 0);
      if (stall > 0) begin
        stall--;
      end
      @(negedge clock);
      idle++;
      assert (idle < WAIT_LIMIT)
        else stop_with_error("Timeout: no output beat from the DUT for too long");
      // Committed bytes can only come from good frames not yet acknowledged
      assert (level_o <= `PKT_DEPTH - 1 && level_o <= exp_bytes.size())
        else stop_with_error($sformatf("Fail %0t: level_o is %0d with %0d bytes pending",
                                       $time, level_o, exp_bytes.size()));
      if (!s_tready_o) begin
        saw_full = 1'b1;
      end
      if (m_tvalid_o && m_tready_i) begin
        idle = 0;
        assert (exp_lens.size() > 0)
          else stop_with_error($sformatf("Fail %0t: unexpected output byte %02h",
                                         $time, m_tdata_o));
        assert (m_tdata_o == exp_bytes[idx])
          else stop_with_error($sformatf("Fail %0t: byte %0d is %02h, expected %02h",
                                         $time, idx, m_tdata_o, exp_bytes[idx]));
        assert (m_tlast_o == (idx == exp_lens[0] - 1))
          else stop_with_error($sformatf("Fail %0t: m_tlast_o is %0b at byte %0d of %0d",
                                         $time, m_tlast_o, idx, exp_lens[0]));
        idx++;
        if (m_tlast_o) begin
          pulse_nak = draw(cons_state, 3) == 0;
          if (!pulse_nak) begin
            repeat (exp_lens[0]) void'(exp_bytes.pop_front());
            void'(exp_lens.pop_front());
            acked++;
            // Long output stalls let the FIFO fill up
            if (acked == 8 || acked == 30) begin
              stall = 200;
            end
          end
          idx = 0;
          @(posedge clock);
          ack_i      <= !pulse_nak;
          nak_i      <= pulse_nak;
          // Output waits while the acknowledge is applied
          m_tready_i <= 1'b0;
          @(posedge clock);
          ack_i <= 1'b0;
          nak_i <= 1'b0;
        end
      end
    end
  endtask

  initial begin
    int waited;
    reset = 1'b1;
    s_tvalid_i = 1'b0;
    s_tkeep_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = '0;
    m_tready_i = 1'b0;
    ack_i = 1'b0;
    nak_i = 1'b0;
    prod_state = SEED;
    cons_state = ~SEED;
    producer_done = 1'b0;
    saw_full = 1'b0;
    errors = 0;
    repeat (15) @(posedge clock);
    @(negedge clock);
    assert (!s_tready_o && !m_tvalid_o && level_o == 0)
      else stop_with_error($sformatf("Fail %0t: outputs not idle during reset", $time));
    @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    assert (!s_tready_o && !m_tvalid_o && level_o == 0)
      else stop_with_error($sformatf("Fail %0t: outputs not idle after reset", $time));
    fork
      send_frames();
      take_frames();
    join
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      assert (waited < 20)
        else stop_with_error("Timeout: level_o did not return to zero after the last ack");
    end while (level_o != 0);
    assert (saw_full)
      else stop_with_error("Input ready never fell while the output was stalled");
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* pkt_link.f */
+incdir+src
src/pkt_pkg.sv
src/crc16_check.sv
src/axis_skid.sv
src/packet_fifo.sv
src/pkt_link.sv
bench/pkt_link_tb.sv

/* Bender.yml */
package:
  name: pkt_link

sources:
  - include_dirs:
      - src
    files:
      - src/pkt_pkg.sv
      - src/crc16_check.sv
      - src/axis_skid.sv
      - src/packet_fifo.sv
      - src/pkt_link.sv
      - target: test
        files:
          - bench/pkt_link_tb.sv
